// File: verilog/maze_geom_pkg.sv
`default_nettype none

package maze_geom_pkg;

	// ####################
	// Grid geometry

	localparam int DEF_COORD_W = 4;	// 16 x 16 cells

	function automatic int num_cells(input int coord_w);
		return 1 << (2 * coord_w);
	endfunction

	// ####################
	// Search directions

	localparam int DIR_W = 2;

	// The position unit steps through these with +1, west is tried last
	typedef enum logic [DIR_W-1:0] {
		dir_north,	// Towards y - 1
		dir_east,	// Towards x + 1
		dir_south,
		dir_west
	} dir_t;

endpackage

`default_nettype wire

// File: verilog/solver_ctrl_pkg.sv
`default_nettype none

package solver_ctrl_pkg;

	localparam int STATE_W = 5;

	typedef enum logic [STATE_W-1:0] {
		st_idle,
		st_init,
		st_mark_visited,	// Current cell gets a wall so it is never entered again
		st_check_goal,
		st_check_cell,
		st_push_loc,
		st_advance,
		st_next_dir,
		// ####################
		// Backtracking
		st_check_empty_stack,
		st_pop_loc,
		st_retry_dir,
		// ####################
		// Path collection and readout
		st_goal_write,
		st_stack_read,
		st_update_list,
		st_fail,
		st_done,
		st_show
	} solver_state_t;

endpackage

`default_nettype wire

// File: verilog/maze_controller.sv
`timescale 1ns/1ps
`default_nettype none

module maze_controller (
	input  logic CLK,
	input  logic RST,
	input  logic start,
	input  logic run,
	input  logic found,
	input  logic blocked,
	input  logic co,
	input  logic empty_stack,
	input  logic complete_read,
	output logic init_pos,
	output logic ld_pos,
	output logic r_update,
	output logic en_dir,
	output logic ld_dir,
	output logic wr,
	output logic init_stack,
	output logic stack_push,
	output logic stack_pop,
	output logic init_list,
	output logic list_push,
	output logic src_goal,
	output logic en_read,
	output logic done,
	output logic fail
);
	import solver_ctrl_pkg::*;

	solver_state_t pstate;
	solver_state_t nstate;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			pstate <= st_idle;
		else
			pstate <= nstate;
	end

	always_comb begin
		nstate = pstate;
		case (pstate)
			st_idle:              nstate = start ? st_init : st_idle;
			st_init:              nstate = st_mark_visited;
			st_mark_visited:      nstate = st_check_goal;
			st_check_goal:        nstate = found ? st_goal_write : st_check_cell;
			st_check_cell: begin
				if (!blocked)
					nstate = st_push_loc;
				else if (!co)
					nstate = st_next_dir;
				else
					nstate = st_check_empty_stack;	// All four directions used up
			end
			st_push_loc:          nstate = st_advance;
			st_advance:           nstate = st_mark_visited;
			st_next_dir:          nstate = st_check_cell;
			st_check_empty_stack: nstate = empty_stack ? st_fail : st_pop_loc;
			st_pop_loc:           nstate = st_retry_dir;
			st_retry_dir:         nstate = co ? st_check_empty_stack : st_next_dir;
			st_goal_write:        nstate = st_stack_read;
			st_stack_read:        nstate = empty_stack ? st_done : st_update_list;
			st_update_list:       nstate = st_stack_read;
			st_fail:              nstate = start ? st_init : st_fail;
			st_done: begin
				if (start)
					nstate = st_init;
				else if (run)
					nstate = st_show;
			end
			st_show:              nstate = complete_read ? st_done : st_show;
			default:              nstate = st_idle;
		endcase
	end

	// Moore outputs
	always_comb begin
		init_pos   = 1'b0;
		ld_pos     = 1'b0;
		r_update   = 1'b0;
		en_dir     = 1'b0;
		ld_dir     = 1'b0;
		wr         = 1'b0;
		init_stack = 1'b0;
		stack_push = 1'b0;
		stack_pop  = 1'b0;
		init_list  = 1'b0;
		list_push  = 1'b0;
		src_goal   = 1'b0;
		en_read    = 1'b0;
		done       = 1'b0;
		fail       = 1'b0;
		case (pstate)
			st_init: begin
				init_pos   = 1'b1;
				init_stack = 1'b1;
				init_list  = 1'b1;
			end
			st_mark_visited: wr = 1'b1;
			st_push_loc:     stack_push = 1'b1;	// Parent cell with the direction taken
			st_advance:      ld_pos = 1'b1;
			st_next_dir:     en_dir = 1'b1;
			st_pop_loc: begin
				stack_pop = 1'b1;
				r_update  = 1'b1;
				ld_dir    = 1'b1;
			end
			st_goal_write: begin
				list_push = 1'b1;
				src_goal  = 1'b1;
			end
			st_update_list: begin
				list_push = 1'b1;	// List takes the top before the pop moves it
				stack_pop = 1'b1;
			end
			st_fail: fail = 1'b1;
			st_done: done = 1'b1;
			st_show: begin
				done    = 1'b1;
				en_read = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/maze_memory.sv
`timescale 1ns/1ps
`default_nettype none

module maze_memory #(
	parameter int COORD_W = maze_geom_pkg::DEF_COORD_W
) (
	input  logic               CLK,
	input  logic               load,
	input  logic [COORD_W-1:0] load_x,
	input  logic [COORD_W-1:0] load_y,
	input  logic               load_wall,
	input  logic               wr,
	input  logic [COORD_W-1:0] wr_x,
	input  logic [COORD_W-1:0] wr_y,
	input  logic [COORD_W-1:0] rd_x,
	input  logic [COORD_W-1:0] rd_y,
	output logic               rd_bit
);
	import maze_geom_pkg::*;

	// A set bit in this row major array is a wall or a visited cell
	logic cells [num_cells(COORD_W)];

	always_ff @(posedge CLK) begin
		if (load)
			cells[{load_y, load_x}] <= load_wall;
		else if (wr)
			cells[{wr_y, wr_x}] <= 1'b1;
	end

	assign rd_bit = cells[{rd_y, rd_x}];

endmodule

`default_nettype wire

// File: verilog/position_unit.sv
`timescale 1ns/1ps
`default_nettype none

module position_unit #(
	parameter int COORD_W = maze_geom_pkg::DEF_COORD_W
) (
	input  logic                           CLK,
	input  logic                           RST,
	input  logic                           init_pos,
	input  logic                           ld_pos,
	input  logic                           r_update,
	input  logic                           en_dir,
	input  logic                           ld_dir,
	input  logic [COORD_W-1:0]             top_x,
	input  logic [COORD_W-1:0]             top_y,
	input  logic [maze_geom_pkg::DIR_W-1:0] top_dir,
	input  logic                           rd_bit,
	output logic [COORD_W-1:0]             cur_x,
	output logic [COORD_W-1:0]             cur_y,
	output logic [maze_geom_pkg::DIR_W-1:0] cur_dir,
	output logic [COORD_W-1:0]             nbr_x,
	output logic [COORD_W-1:0]             nbr_y,
	output logic                           found,
	output logic                           blocked,
	output logic                           co
);
	import maze_geom_pkg::*;

	localparam logic [COORD_W-1:0] EDGE_MAX = '1;

	dir_t dir;
	logic oob;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			cur_x <= '0;
			cur_y <= '0;
			dir   <= dir_north;
		end else begin
			if (init_pos) begin
				cur_x <= '0;
				cur_y <= '0;
			end else if (ld_pos) begin
				cur_x <= nbr_x;
				cur_y <= nbr_y;
			end else if (r_update) begin
				cur_x <= top_x;
				cur_y <= top_y;
			end
			if (init_pos || ld_pos)
				dir <= dir_north;	// A fresh cell is scanned from the first direction
			else if (ld_dir)
				dir <= dir_t'(top_dir);
			else if (en_dir)
				dir <= dir_t'(dir + 1'b1);
		end
	end

	// Neighbor wraps at the edges, oob masks it
	always_comb begin
		nbr_x = cur_x;
		nbr_y = cur_y;
		oob   = 1'b0;
		case (dir)
			dir_north: begin
				nbr_y = cur_y - 1'b1;
				oob   = (cur_y == '0);
			end
			dir_east: begin
				nbr_x = cur_x + 1'b1;
				oob   = (cur_x == EDGE_MAX);
			end
			dir_south: begin
				nbr_y = cur_y + 1'b1;
				oob   = (cur_y == EDGE_MAX);
			end
			default: begin
				nbr_x = cur_x - 1'b1;
				oob   = (cur_x == '0);
			end
		endcase
	end

	assign blocked = oob | rd_bit;
	assign found   = (cur_x == EDGE_MAX) && (cur_y == EDGE_MAX);
	assign co      = (dir == dir_west);
	assign cur_dir = dir;

endmodule

`default_nettype wire

// File: verilog/location_stack.sv
`timescale 1ns/1ps
`default_nettype none

module location_stack #(
	parameter int COORD_W     = maze_geom_pkg::DEF_COORD_W,
	parameter int STACK_DEPTH = maze_geom_pkg::num_cells(maze_geom_pkg::DEF_COORD_W)
) (
	input  logic                            CLK,
	input  logic                            RST,
	input  logic                            init_stack,
	input  logic                            stack_push,
	input  logic                            stack_pop,
	input  logic [COORD_W-1:0]              push_x,
	input  logic [COORD_W-1:0]              push_y,
	input  logic [maze_geom_pkg::DIR_W-1:0] push_dir,
	output logic [COORD_W-1:0]              top_x,
	output logic [COORD_W-1:0]              top_y,
	output logic [maze_geom_pkg::DIR_W-1:0] top_dir,
	output logic                            empty_stack
);
	import maze_geom_pkg::*;

	localparam int ADDR_W  = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;
	localparam int PTR_W   = $clog2(STACK_DEPTH + 1);
	localparam int ENTRY_W = 2 * COORD_W + DIR_W;

	logic [ENTRY_W-1:0] mem [STACK_DEPTH];
	logic [PTR_W-1:0]   ptr;	// Number of entries held
	logic [PTR_W-1:0]   top_ptr;

	always_ff @(posedge CLK) begin
		if (stack_push)
			mem[ptr[ADDR_W-1:0]] <= {push_x, push_y, push_dir};
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			ptr <= '0;
		else if (init_stack)
			ptr <= '0;
		else if (stack_push)
			ptr <= ptr + 1'b1;
		else if (stack_pop)
			ptr <= ptr - 1'b1;
	end

	assign top_ptr = ptr - 1'b1;
	assign {top_x, top_y, top_dir} = mem[top_ptr[ADDR_W-1:0]];
	assign empty_stack = (ptr == '0);

endmodule

`default_nettype wire

// File: verilog/path_list.sv
`timescale 1ns/1ps
`default_nettype none

module path_list #(
	parameter int COORD_W     = maze_geom_pkg::DEF_COORD_W,
	parameter int STACK_DEPTH = maze_geom_pkg::num_cells(maze_geom_pkg::DEF_COORD_W)
) (
	input  logic               CLK,
	input  logic               RST,
	input  logic               init_list,
	input  logic               list_push,
	input  logic               src_goal,
	input  logic [COORD_W-1:0] cur_x,
	input  logic [COORD_W-1:0] cur_y,
	input  logic [COORD_W-1:0] top_x,
	input  logic [COORD_W-1:0] top_y,
	input  logic               en_read,
	output logic               path_valid,
	output logic [COORD_W-1:0] path_x,
	output logic [COORD_W-1:0] path_y,
	output logic               path_last,
	output logic               complete_read
);
	localparam int ADDR_W = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;
	localparam int PTR_W  = $clog2(STACK_DEPTH + 1);

	logic [2*COORD_W-1:0] mem [STACK_DEPTH];
	logic [PTR_W-1:0]     count;
	logic [PTR_W-1:0]     rd_ptr;
	logic                 last;

	// Entry 0 is the goal, the start cell is appended last
	always_ff @(posedge CLK) begin
		if (list_push)
			mem[count[ADDR_W-1:0]] <= src_goal ? {cur_x, cur_y} : {top_x, top_y};
		if (en_read)
			{path_x, path_y} <= mem[rd_ptr[ADDR_W-1:0]];
	end

	assign last          = (rd_ptr == count - 1'b1);
	assign complete_read = en_read & last;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			count      <= '0;
			rd_ptr     <= '0;
			path_valid <= 1'b0;
			path_last  <= 1'b0;
		end else begin
			path_valid <= en_read;
			path_last  <= complete_read;
			if (init_list) begin
				count  <= '0;
				rd_ptr <= '0;
			end else begin
				if (list_push)
					count <= count + 1'b1;
				if (en_read)
					rd_ptr <= last ? '0 : rd_ptr + 1'b1;	// Rewound for the next run
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/maze_solver.sv
`timescale 1ns/1ps
`default_nettype none

module maze_solver #(
	parameter int COORD_W = maze_geom_pkg::DEF_COORD_W
) (
	input  logic               CLK,
	input  logic               RST,
	input  logic               load,
	input  logic [COORD_W-1:0] load_x,
	input  logic [COORD_W-1:0] load_y,
	input  logic               load_wall,
	input  logic               start,
	input  logic               run,
	output logic               done,
	output logic               fail,
	output logic               path_valid,
	output logic [COORD_W-1:0] path_x,
	output logic [COORD_W-1:0] path_y,
	output logic               path_last
);
	import maze_geom_pkg::*;

	localparam int STACK_DEPTH = num_cells(COORD_W);	// Worst case holds every cell

	// ####################
	// Control strobes and status
	logic init_pos, ld_pos, r_update, en_dir, ld_dir, wr;
	logic init_stack, stack_push, stack_pop;
	logic init_list, list_push, src_goal, en_read;
	logic found, blocked, co, empty_stack, complete_read, rd_bit;

	// ####################
	// Datapath
	logic [COORD_W-1:0] cur_x, cur_y, nbr_x, nbr_y, top_x, top_y;
	logic [DIR_W-1:0]   cur_dir, top_dir;

	maze_controller u_ctrl (.*);

	maze_memory #(.COORD_W(COORD_W)) u_mem (
		.*,
		.wr_x (cur_x),
		.wr_y (cur_y),
		.rd_x (nbr_x),
		.rd_y (nbr_y)
	);

	position_unit #(.COORD_W(COORD_W)) u_pos (.*);

	location_stack #(
		.COORD_W     (COORD_W),
		.STACK_DEPTH (STACK_DEPTH)
	) u_stack (
		.*,
		.push_x   (cur_x),
		.push_y   (cur_y),
		.push_dir (cur_dir)
	);

	path_list #(
		.COORD_W     (COORD_W),
		.STACK_DEPTH (STACK_DEPTH)
	) u_list (.*);

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter real PERIOD = 8.0
) (
	output logic CLK
);
	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2.0) CLK = ~CLK;
	end

endmodule

`default_nettype wire

// File: bench/maze_solver_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module maze_solver_assertions #(
	parameter int COORD_W = 4
) (
	input logic               CLK,
	input logic               RST,
	input logic               start,
	input logic               run,
	input logic               done,
	input logic               fail,
	input logic               path_valid,
	input logic [COORD_W-1:0] path_x,
	input logic [COORD_W-1:0] path_y,
	input logic               path_last
);
	int assert_fails = 0;

	function automatic bit one_step(
		input logic [COORD_W-1:0] ax,
		input logic [COORD_W-1:0] ay,
		input logic [COORD_W-1:0] bx,
		input logic [COORD_W-1:0] by
	);
		int dx;
		int dy;
		dx = (ax > bx) ? ax - bx : bx - ax;
		dy = (ay > by) ? ay - by : by - ay;
		return (dx + dy) == 1;
	endfunction

	task automatic flag_failure(input string what);
		$error("%s", what);
		assert_fails++;
	endtask

	// ####################
	// Status levels

	reset_quiet: assert property (@(posedge CLK) RST |-> !done && !fail && !path_valid)
		else flag_failure("done, fail or path_valid is high during reset");
	done_xor_fail: assert property (@(posedge CLK) disable iff (RST) !(done && fail))
		else flag_failure("done and fail are high together");
	status_hold: assert property (@(posedge CLK) disable iff (RST)
		(done || fail) && !start |=> $stable(done) && $stable(fail))
		else flag_failure("done or fail changed without a start strobe");
	fail_silent: assert property (@(posedge CLK) disable iff (RST) fail |-> !path_valid)
		else flag_failure("path_valid appeared while fail was high");

	// ####################
	// Readout stream

	read_latency: assert property (@(posedge CLK) disable iff (RST)
		run && done && !start && !path_valid |-> ##2 path_valid)
		else flag_failure("First path entry did not follow the run strobe by 2 cycles");
	path_steps: assert property (@(posedge CLK) disable iff (RST)
		path_valid && !path_last |=> path_valid
			&& one_step($past(path_x), $past(path_y), path_x, path_y))
		else flag_failure("Consecutive path entries are not one step apart");
	ends_at_start: assert property (@(posedge CLK) disable iff (RST)
		path_last |-> path_valid && path_x == '0 && path_y == '0)
		else flag_failure("Last path entry is not the start cell");

endmodule

bind maze_solver maze_solver_assertions #(.COORD_W(COORD_W)) u_sva (.*);

`default_nettype wire

// File: bench/maze_solver_tb.sv
`timescale 1ns/1ps
`default_nettype none

module maze_solver_tb;
	localparam int COORD_W      = 4;
	localparam int SIDE         = 1 << COORD_W;
	localparam int LAST         = SIDE - 1;
	localparam int SEARCH_LIMIT = 50000;	// Well above the cycles of a full exploration
	localparam int READ_LIMIT   = 4 * SIDE * SIDE;

	logic               CLK;
	logic               RST;
	logic               load;
	logic [COORD_W-1:0] load_x;
	logic [COORD_W-1:0] load_y;
	logic               load_wall;
	logic               start;
	logic               run;
	logic               done;
	logic               fail;
	logic               path_valid;
	logic [COORD_W-1:0] path_x;
	logic [COORD_W-1:0] path_y;
	logic               path_last;

	bit          maze [SIDE][SIDE];	// Indexed [y][x] where a set bit is a wall
	int          exp_path [$];	// Cells as y * SIDE + x with the goal first
	int          got_path [$];
	logic [31:0] lfsr     = 32'he161_5603;
	int          errors   = 0;
	int          timeouts = 0;

	clock_gen u_clk (.CLK(CLK));

	maze_solver #(.COORD_W(COORD_W)) u_dut (.*);

	// ####################
	// Maze construction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// x^32 + x^22 + x^2 + x + 1
	endfunction

	task automatic take_bit(output bit b);
		lfsr = lfsr_step(lfsr);
		b    = lfsr[0];
	endtask

	// Even rows are open, odd rows open one cell at alternating ends
	function automatic bit corridor_wall(input int x, input int y);
		if (y >= SIDE - 2)
			return x != LAST;
		if (y % 2 == 0)
			return 1'b0;
		return x != ((y % 4 == 1) ? LAST : 0);
	endfunction

	task automatic build_corridor();
		exp_path.delete();
		for (int y = 0; y < SIDE; y++) begin
			for (int x = 0; x < SIDE; x++)
				maze[y][x] = corridor_wall(x, y);
		end
		for (int y = 0; y < SIDE - 2; y += 2) begin
			for (int i = 0; i < SIDE; i++)
				exp_path.push_front(y * SIDE + ((y % 4 == 0) ? i : LAST - i));
			exp_path.push_front((y + 1) * SIDE + ((y % 4 == 0) ? LAST : 0));
		end
		exp_path.push_front((SIDE - 2) * SIDE + LAST);
		exp_path.push_front(LAST * SIDE + LAST);
	endtask

	task automatic build_random(input bit sparse);
		bit b0;
		bit b1;
		bit b2;
		for (int y = 0; y < SIDE; y++) begin
			for (int x = 0; x < SIDE; x++) begin
				take_bit(b0);
				take_bit(b1);
				if (sparse) begin
					maze[y][x] = b0 & b1;	// About a quarter walls
				end else begin
					take_bit(b2);
					maze[y][x] = (b0 & b1) | (b0 & b2) | (b1 & b2);	// Half walls
				end
			end
		end
		maze[0][0]       = 1'b0;
		maze[LAST][LAST] = 1'b0;
	endtask

	// Breadth first flood fill from the start cell
	function automatic bit goal_reachable();
		bit seen [SIDE][SIDE];
		int q [$];
		int c;
		int x;
		int y;
		int nx;
		int ny;
		q.push_back(0);
		seen[0][0] = 1'b1;
		while (q.size() > 0) begin
			c = q.pop_front();
			x = c % SIDE;
			y = c / SIDE;
			if (x == LAST && y == LAST)
				return 1'b1;
			for (int d = 0; d < 4; d++) begin
				nx = x + ((d == 1) ? 1 : (d == 3) ? -1 : 0);
				ny = y + ((d == 2) ? 1 : (d == 0) ? -1 : 0);
				if (nx >= 0 && nx < SIDE && ny >= 0 && ny < SIDE
						&& !maze[ny][nx] && !seen[ny][nx]) begin
					seen[ny][nx] = 1'b1;
					q.push_back(ny * SIDE + nx);
				end
			end
		end
		return 1'b0;
	endfunction

	// ####################
	// DUT access

	task automatic load_maze();
		for (int y = 0; y < SIDE; y++) begin
			for (int x = 0; x < SIDE; x++) begin
				@(negedge CLK);
				load      = 1'b1;
				load_x    = x[COORD_W-1:0];
				load_y    = y[COORD_W-1:0];
				load_wall = maze[y][x];
			end
		end
		@(negedge CLK);
		load = 1'b0;
	endtask

	task automatic run_search();
		int cycles;
		@(negedge CLK);
		start = 1'b1;
		@(negedge CLK);
		start  = 1'b0;
		cycles = 0;
		while (!done && !fail && cycles < SEARCH_LIMIT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!done && !fail) begin
			$display("Search gave neither done nor fail within %0d cycles", SEARCH_LIMIT);
			timeouts++;
		end
	endtask

	task automatic read_path();
		int cycles;
		bit finished;
		got_path.delete();
		@(negedge CLK);
		run = 1'b1;
		@(negedge CLK);
		run      = 1'b0;
		cycles   = 0;
		finished = 1'b0;
		while (!finished && cycles < READ_LIMIT) begin
			@(negedge CLK);
			cycles++;
			if (path_valid) begin
				got_path.push_back(path_y * SIDE + path_x);
				finished = path_last;
			end
		end
		if (!finished) begin
			$display("Path readout did not reach path_last within %0d cycles", READ_LIMIT);
			timeouts++;
		end
	endtask

	// A readout would start 2 cycles after the strobe if it were taken
	task automatic pulse_run();
		@(negedge CLK);
		run = 1'b1;
		@(negedge CLK);
		run = 1'b0;
		repeat (3) @(negedge CLK);
	endtask

	// ####################
	// Checks

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0b expected %0b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_path();
		if (got_path.size() != exp_path.size()) begin
			$display("Mismatch at %0t: path length got %0d expected %0d",
				$time, got_path.size(), exp_path.size());
			errors++;
		end
		for (int i = 0; i < got_path.size() && i < exp_path.size(); i++) begin
			if (got_path[i] != exp_path[i]) begin
				$display("Mismatch at %0t: entry %0d path_x,path_y got %0d,%0d expected %0d,%0d",
					$time, i, got_path[i] % SIDE, got_path[i] / SIDE,
					exp_path[i] % SIDE, exp_path[i] / SIDE);
				errors++;
			end
		end
	endtask

	task automatic check_free_cells();
		int x;
		int y;
		if (got_path.size() == 0 || got_path[0] != LAST * SIDE + LAST) begin
			$display("Streamed path does not begin at the goal cell");
			errors++;
		end
		foreach (got_path[i]) begin
			x = got_path[i] % SIDE;
			y = got_path[i] / SIDE;
			if (maze[y][x]) begin
				$display("Path entry %0d at (%0d, %0d) is a wall in the loaded maze", i, x, y);
				errors++;
			end
		end
	endtask

	// ####################
	// Test sequence

	initial begin
		bit reach;
		RST       = 1'b1;
		load      = 1'b0;
		load_x    = '0;
		load_y    = '0;
		load_wall = 1'b0;
		start     = 1'b0;
		run       = 1'b0;
		repeat (10) @(negedge CLK);
		RST = 1'b0;

		build_corridor();
		load_maze();
		run_search();
		check_flag("done", done, 1'b1);
		check_flag("fail", fail, 1'b0);
		read_path();
		compare_path();
		read_path();	// Second readout of the same solution
		compare_path();

		maze[LAST - 1][LAST] = 1'b1;	// Goal cut off from its only neighbor
		load_maze();
		run_search();
		check_flag("fail", fail, 1'b1);
		check_flag("done", done, 1'b0);
		pulse_run();	// No readout may start while the search has failed
		check_flag("fail", fail, 1'b1);

		build_corridor();
		load_maze();
		run_search();
		check_flag("done", done, 1'b1);
		read_path();
		compare_path();

		for (int m = 0; m < 8; m++) begin
			build_random(m % 2 == 0);
			reach = goal_reachable();
			load_maze();
			run_search();
			check_flag("fail", fail, !reach);
			check_flag("done", done, reach);
			if (done && reach) begin
				read_path();
				check_free_cells();
			end
		end

		repeat (4) @(negedge CLK);
		$display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
			errors, timeouts, u_dut.u_sva.assert_fails);
		if (errors == 0 && timeouts == 0 && u_dut.u_sva.assert_fails == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: maze_solver.f
verilog/maze_geom_pkg.sv
verilog/solver_ctrl_pkg.sv
verilog/maze_controller.sv
verilog/maze_memory.sv
verilog/position_unit.sv
verilog/location_stack.sv
verilog/path_list.sv
verilog/maze_solver.sv
bench/clock_gen.sv
bench/maze_solver_assertions.sv
bench/maze_solver_tb.sv
